/* all.f */
design/uart_ahb_pkg.sv
design/uart_baud_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_decode.sv
design/ahb_execute.sv
design/read_result.sv
design/uart_ahb_master.sv
dv/uart_ahb_tb.sv

/* Bender.yml */
package:
  name: uart_ahb_master

sources:
  - files:
      - design/uart_ahb_pkg.sv
      - design/uart_baud_gen.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/cmd_decode.sv
      - design/ahb_execute.sv
      - design/read_result.sv
      - design/uart_ahb_master.sv
  - target: test
    files:
      - dv/uart_ahb_tb.sv

/* dv/uart_ahb_tb.sv */
module uart_ahb_tb;

  localparam uart_ahb_pkg::prescale_t PRESCALE = 16'd3;
  localparam int BIT_CLKS      = uart_ahb_pkg::OVERSAMPLE * (PRESCALE + 1); // 64 clocks
  localparam int RESP_TIMEOUT  = 120 * BIT_CLKS; // covers a whole read command plus latency
  localparam int DRAIN_TIMEOUT = 40 * BIT_CLKS;
  localparam uart_ahb_pkg::data_t UNWRITTEN_MASK = 32'h5a5a_0000;

  // one logged AHB transfer
  typedef struct packed {
    uart_ahb_pkg::addr_t addr;
    logic                write;
    logic [2:0]          size;
    uart_ahb_pkg::data_t wdata;
  } bus_rec_t;

  logic                HCLK = 1'b0;
  logic                HRESETn;
  uart_ahb_pkg::addr_t HADDR;
  logic [1:0]          HTRANS;
  logic [2:0]          HSIZE;
  logic                HWRITE;
  uart_ahb_pkg::data_t HWDATA;
  logic                HREADY;
  uart_ahb_pkg::data_t HRDATA;
  logic                RX;
  logic                TX;

  uart_ahb_pkg::data_t mem [uart_ahb_pkg::addr_t];    // slave storage
  uart_ahb_pkg::data_t shadow [uart_ahb_pkg::addr_t]; // reference copy, never read by the slave
  bus_rec_t            bus_log[$];
  bus_rec_t            exp_bus[$];
  uart_ahb_pkg::data_t got_words[$];
  uart_ahb_pkg::data_t exp_words[$];

  int   xfer_cnt = 0;
  int   tx_falls = 0;
  int   tx_hold  = 0; // clocks left in the current TX frame
  logic tx_prev  = 1'b1;
  int   err_cnt  = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   err_mark;
  int   xfer_mark;
  int   fall_mark;
  bit   timed_out = 1'b0;

  uart_ahb_master #(.PRESCALE(PRESCALE)) uut (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HTRANS(HTRANS), .HSIZE(HSIZE),
    .HWRITE(HWRITE), .HWDATA(HWDATA), .HREADY(HREADY), .HRDATA(HRDATA), .RX(RX), .TX(TX)
  );

  always #2 HCLK = ~HCLK;

  // last value written, else the address pattern
  function automatic uart_ahb_pkg::data_t expected_word(input uart_ahb_pkg::addr_t a);
    if (shadow.exists(a))
      return shadow[a];
    return a ^ UNWRITTEN_MASK;
  endfunction

  // counts start bits on TX, skipping the data bits of each frame
  always @(posedge HCLK)
  begin
    if (tx_hold != 0)
      tx_hold--;
    else if (tx_prev && !TX)
    begin
      tx_falls++;
      tx_hold = 9 * BIT_CLKS + BIT_CLKS / 2; // into the stop bit
    end
    tx_prev <= TX;
  end

  always @(posedge HCLK)
  begin : compare
    uart_ahb_pkg::data_t exp_w;
    uart_ahb_pkg::data_t got_w;
    bus_rec_t            eb;
    bus_rec_t            gb;
    if (exp_words.size() != 0 && got_words.size() != 0)
    begin
      exp_w = exp_words.pop_front();
      got_w = got_words.pop_front();
      if (got_w !== exp_w)
      begin
        $display("** Error at %0t: read data %h, expected %h", $time, got_w, exp_w);
        err_cnt++;
      end
    end
    if (exp_bus.size() != 0 && bus_log.size() != 0)
    begin
      eb = exp_bus.pop_front();
      gb = bus_log.pop_front();
      if (gb.addr !== eb.addr || gb.write !== eb.write || gb.size !== eb.size ||
          (eb.write && gb.wdata !== eb.wdata))
      begin
        $display("** Error at %0t: transfer %h/%b/%b/%h, expected %h/%b/%b/%h", $time,
                 gb.addr, gb.write, gb.size, gb.wdata, eb.addr, eb.write, eb.size, eb.wdata);
        err_cnt++;
      end
    end
  end

  // holds HREADY low for some cycles, returns on the edge that ends the phase
  task automatic phase_wait(input int waits);
    if (waits > 0)
    begin
      HREADY <= 1'b0;
      repeat (waits) @(posedge HCLK);
    end
    HREADY <= 1'b1;
    @(posedge HCLK);
  endtask

  initial
  begin : ahb_slave
    bus_rec_t rec;
    HREADY = 1'b0; // idle low, so each address phase sees one wait at least
    HRDATA = '0;
    forever
    begin
      @(posedge HCLK);
      if (HRESETn && HTRANS == uart_ahb_pkg::HTRANS_NONSEQ)
      begin
        rec.addr  = HADDR;
        rec.write = HWRITE;
        rec.size  = HSIZE;
        rec.wdata = '0;
        xfer_cnt++;
        phase_wait($urandom % 4);
        HRDATA <= mem.exists(rec.addr) ? mem[rec.addr] : rec.addr ^ UNWRITTEN_MASK;
        phase_wait($urandom % 4);
        if (rec.write)
        begin
          rec.wdata      = HWDATA;
          mem[rec.addr] = HWDATA;
        end
        HREADY <= 1'b0;
        bus_log.push_back(rec);
      end
    end
  end

  task automatic send_byte(input uart_ahb_pkg::byte_t b);
    int i;
    @(posedge HCLK);
    RX <= 1'b0;
    repeat (BIT_CLKS) @(posedge HCLK);
    for (i = 0; i < 8; i++)
    begin
      RX <= b[i];
      repeat (BIT_CLKS) @(posedge HCLK);
    end
    RX <= 1'b1;
    repeat (BIT_CLKS - 1) @(posedge HCLK);
  endtask

  task automatic send_word(input uart_ahb_pkg::data_t w);
    int k;
    for (k = 0; k < 4; k++)
      send_byte(w[8*k +: 8]); // lsb first
  endtask

  task automatic recv_byte(output uart_ahb_pkg::byte_t b, output bit ok);
    int n;
    int i;
    ok = 1'b0;
    b  = '0;
    n  = 0;
    while (TX !== 1'b0 && n < RESP_TIMEOUT)
    begin
      @(posedge HCLK);
      n++;
    end
    if (TX !== 1'b0)
    begin
      $display("timeout: no start bit on TX within %0d clocks", RESP_TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    repeat (BIT_CLKS / 2) @(posedge HCLK); // mid start bit
    if (TX !== 1'b0)
    begin
      $display("** Error at %0t: start bit on TX too short", $time);
      err_cnt++;
    end
    for (i = 0; i < 8; i++)
    begin
      repeat (BIT_CLKS) @(posedge HCLK);
      b[i] = TX;
    end
    repeat (BIT_CLKS) @(posedge HCLK);
    if (TX !== 1'b1)
    begin
      $display("** Error at %0t: stop bit on TX is low", $time);
      err_cnt++;
    end
    ok = 1'b1;
  endtask

  task automatic recv_word();
    uart_ahb_pkg::data_t w;
    uart_ahb_pkg::byte_t b;
    bit                  ok;
    int                  k;
    w = '0;
    for (k = 0; k < 4; k++)
    begin
      recv_byte(b, ok);
      if (!ok)
        return;
      w[8*k +: 8] = b;
    end
    got_words.push_back(w);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_words.size() != 0 || exp_bus.size() != 0) && !timed_out && n < DRAIN_TIMEOUT)
    begin
      @(posedge HCLK);
      n++;
    end
    if (!timed_out && (exp_words.size() != 0 || exp_bus.size() != 0))
    begin
      $display("timeout: an expected bus transfer or read response never arrived");
      timed_out = 1'b1;
    end
  endtask

  task automatic do_write(input uart_ahb_pkg::addr_t a, input uart_ahb_pkg::data_t d);
    bus_rec_t rec;
    rec.addr  = a;
    rec.write = 1'b1;
    rec.size  = uart_ahb_pkg::HSIZE_WORD;
    rec.wdata = d;
    exp_bus.push_back(rec);
    shadow[a] = d;
    send_byte(uart_ahb_pkg::OP_WRITE);
    send_word(a);
    send_word(d);
    wait_drain();
  endtask

  task automatic do_read(input uart_ahb_pkg::addr_t a);
    bus_rec_t rec;
    rec.addr  = a;
    rec.write = 1'b0;
    rec.size  = uart_ahb_pkg::HSIZE_WORD;
    rec.wdata = '0;
    exp_bus.push_back(rec);
    exp_words.push_back(expected_word(a));
    fork
      begin
        send_byte(uart_ahb_pkg::OP_READ);
        send_word(a);
      end
      recv_word(); // response may start before the last stop bit ends
    join
    wait_drain();
  endtask

  task automatic begin_test();
    err_mark  = err_cnt;
    xfer_mark = xfer_cnt;
    fall_mark = tx_falls;
  endtask

  task automatic check_counts(input int xfers, input int falls);
    if (xfer_cnt - xfer_mark != xfers)
    begin
      $display("** Error at %0t: %0d bus transfers, expected %0d", $time,
               xfer_cnt - xfer_mark, xfers);
      err_cnt++;
    end
    if (tx_falls - fall_mark != falls)
    begin
      $display("** Error at %0t: %0d bytes on TX, expected %0d", $time,
               tx_falls - fall_mark, falls);
      err_cnt++;
    end
    if (bus_log.size() != 0 || got_words.size() != 0)
    begin
      $display("** Error at %0t: unmatched transfers or responses left over", $time);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != err_mark || timed_out)
    begin
      tests_failed++;
      $display("test %s: FAILED", name);
    end
    else
      $display("test %s: ok", name);
  endtask

  task automatic test_reset();
    int i;
    int bad;
    bad = 0;
    begin_test();
    for (i = 0; i < 4 * BIT_CLKS; i++)
    begin
      @(posedge HCLK);
      if (TX !== 1'b1 || HTRANS !== uart_ahb_pkg::HTRANS_IDLE || HWRITE !== 1'b0)
        bad++;
    end
    if (bad != 0)
    begin
      $display("** Error at %0t: bus or TX active after reset in %0d cycles", $time, bad);
      err_cnt++;
    end
    check_counts(0, 0);
    end_test("reset");
  endtask

  task automatic test_random();
    uart_ahb_pkg::addr_t a;
    int                  i;
    int                  reads;
    begin_test();
    reads = 0;
    for (i = 0; i < 20; i++)
    begin
      if (timed_out)
        break;
      a = 32'h2000_0000 | (($urandom % 8) << 2); // small pool, reads hit old writes
      if ($urandom % 2)
        do_write(a, $urandom);
      else
      begin
        do_read(a);
        reads++;
      end
    end
    check_counts(20, 4 * reads);
    end_test("random");
  endtask

  initial
  begin : main
    HRESETn = 1'b0;
    RX      = 1'b1;
    void'($urandom(32'hfd49));
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;
    test_reset();
    if (!timed_out)
    begin
      begin_test();
      do_write(32'h1000_0010, 32'hcafe_f00d);
      repeat (2 * BIT_CLKS) @(posedge HCLK); // TX must stay quiet
      check_counts(1, 0);
      end_test("write");
    end
    if (!timed_out)
    begin
      begin_test();
      do_read(32'h1000_0010);
      check_counts(1, 4);
      end_test("read_back");
    end
    if (!timed_out)
    begin
      begin_test();
      do_read(32'h1000_0400);
      check_counts(1, 4);
      end_test("unwritten_read");
    end
    if (!timed_out)
    begin
      begin_test();
      send_byte(8'h55);
      repeat (2 * BIT_CLKS) @(posedge HCLK);
      check_counts(0, 0);
      do_read(32'h1000_0010);
      check_counts(1, 4);
      end_test("ignored_byte");
    end
    if (!timed_out)
      test_random();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0 && !timed_out)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* design/uart_ahb_master.sv */
module uart_ahb_master #(
  parameter uart_ahb_pkg::prescale_t PRESCALE = 16'd51
) (
  input  logic                HCLK,
  input  logic                HRESETn,
  output uart_ahb_pkg::addr_t HADDR,
  output logic [1:0]          HTRANS,
  output logic [2:0]          HSIZE,
  output logic                HWRITE,
  output uart_ahb_pkg::data_t HWDATA,
  input  logic                HREADY,
  input  uart_ahb_pkg::data_t HRDATA,
  input  logic                RX,
  output logic                TX
);

  logic                   baud_tick;
  uart_ahb_pkg::byte_t    rx_byte;
  logic                   rx_valid;
  uart_ahb_pkg::ahb_cmd_t cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;
  uart_ahb_pkg::data_t    rd_data;
  logic                   rd_valid;
  logic                   rd_ready;
  uart_ahb_pkg::byte_t    tx_byte;
  logic                   tx_start;
  logic                   tx_done;

  assign HSIZE = uart_ahb_pkg::HSIZE_WORD; // word transfers only

  uart_baud_gen #(.PRESCALE(PRESCALE)) u_baud_gen (
    .HCLK(HCLK), .HRESETn(HRESETn), .baud_tick(baud_tick)
  );

  uart_rx u_rx (
    .HCLK(HCLK), .HRESETn(HRESETn), .baud_tick(baud_tick),
    .rx(RX), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  uart_tx u_tx (
    .HCLK(HCLK), .HRESETn(HRESETn), .baud_tick(baud_tick), .tx_start(tx_start),
    .tx_byte(tx_byte), .tx(TX), .tx_done(tx_done)
  );

  cmd_decode u_decode (
    .HCLK(HCLK), .HRESETn(HRESETn), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready)
  );

  ahb_execute u_execute (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .haddr(HADDR), .htrans(HTRANS), .hwrite(HWRITE), .hwdata(HWDATA),
    .hready(HREADY), .hrdata(HRDATA),
    .rd_data(rd_data), .rd_valid(rd_valid), .rd_ready(rd_ready)
  );

  read_result u_result (
    .HCLK(HCLK), .HRESETn(HRESETn), .rd_data(rd_data), .rd_valid(rd_valid),
    .rd_ready(rd_ready), .tx_byte(tx_byte), .tx_start(tx_start), .tx_done(tx_done)
  );

endmodule

/* design/read_result.sv */
module read_result (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  uart_ahb_pkg::data_t rd_data,
  input  logic                rd_valid,
  output logic                rd_ready,
  output uart_ahb_pkg::byte_t tx_byte,
  output logic                tx_start,
  input  logic                tx_done
);

  localparam int               IDX_W     = $clog2(uart_ahb_pkg::BYTES_PER_WORD);
  localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(uart_ahb_pkg::BYTES_PER_WORD - 1);

  logic                busy;
  logic [IDX_W-1:0]    idx;  // byte being sent
  uart_ahb_pkg::data_t word;
  logic                accept;

  assign accept = rd_valid && !busy;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      busy     <= 1'b0;
      idx      <= '0;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= accept || (busy && tx_done && idx != LAST_BYTE);
      if (accept)
      begin
        busy <= 1'b1;
        idx  <= '0;
      end
      else if (busy && tx_done)
      begin
        idx <= idx + 1'b1;
        if (idx == LAST_BYTE)
          busy <= 1'b0; // last stop bit is out
      end
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (accept)
      word <= rd_data;
  end

  assign rd_ready = !busy;
  assign tx_byte  = word[8*idx +: 8]; // lsb first

endmodule

/* design/ahb_execute.sv */
module ahb_execute (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  uart_ahb_pkg::ahb_cmd_t cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output uart_ahb_pkg::addr_t    haddr,
  output logic [1:0]             htrans,
  output logic                   hwrite,
  output uart_ahb_pkg::data_t    hwdata,
  input  logic                   hready,
  input  uart_ahb_pkg::data_t    hrdata,
  output uart_ahb_pkg::data_t    rd_data,
  output logic                   rd_valid,
  input  logic                   rd_ready
);

  typedef enum logic [1:0] {
    E_IDLE,
    E_ADDR,
    E_DATA,
    E_RESULT
  } exec_state_t;

  exec_state_t            state;
  uart_ahb_pkg::ahb_cmd_t req;     // accepted command
  uart_ahb_pkg::data_t    rdata_q;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state <= E_IDLE;
    else
    begin
      case (state)
        E_IDLE:   if (cmd_valid) state <= E_ADDR;
        E_ADDR:   if (hready) state <= E_DATA;
        E_DATA:   if (hready) state <= req.write ? E_IDLE : E_RESULT;
        default:  if (rd_ready) state <= E_IDLE; // serializer took the word
      endcase
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (state == E_IDLE && cmd_valid)
      req <= cmd;
    if (state == E_DATA && hready && !req.write)
      rdata_q <= hrdata;
  end

  assign cmd_ready = (state == E_IDLE);
  assign haddr     = req.addr;
  assign htrans    = (state == E_ADDR) ? uart_ahb_pkg::HTRANS_NONSEQ : uart_ahb_pkg::HTRANS_IDLE;
  assign hwrite    = (state == E_ADDR) && req.write;
  assign hwdata    = req.wdata; // sampled by the slave in the data phase
  assign rd_data   = rdata_q;
  assign rd_valid  = (state == E_RESULT);

endmodule

/* design/cmd_decode.sv */
module cmd_decode (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  uart_ahb_pkg::byte_t    rx_byte,
  input  logic                   rx_valid,
  output uart_ahb_pkg::ahb_cmd_t cmd,
  output logic                   cmd_valid,
  input  logic                   cmd_ready
);

  localparam int         IDX_W     = $clog2(uart_ahb_pkg::BYTES_PER_WORD);
  localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(uart_ahb_pkg::BYTES_PER_WORD - 1);

  typedef enum logic [1:0] {
    S_OPCODE,
    S_ADDR,
    S_WDATA,
    S_HOLD
  } dec_state_t;

  dec_state_t       state;
  logic [IDX_W-1:0] idx; // byte lane within addr or wdata
  logic             is_opcode;

  assign is_opcode = (rx_byte == uart_ahb_pkg::OP_READ) ||
                     (rx_byte == uart_ahb_pkg::OP_WRITE);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state <= S_OPCODE;
      idx   <= '0;
    end
    else
    begin
      case (state)
        S_OPCODE:
          if (rx_valid && is_opcode) // anything else is dropped here
          begin
            state <= S_ADDR;
            idx   <= '0;
          end
        S_ADDR:
          if (rx_valid)
          begin
            idx <= idx + 1'b1;
            if (idx == LAST_BYTE)
              state <= cmd.write ? S_WDATA : S_HOLD;
          end
        S_WDATA:
          if (rx_valid)
          begin
            idx <= idx + 1'b1;
            if (idx == LAST_BYTE)
              state <= S_HOLD;
          end
        default:
          if (cmd_ready)
            state <= S_OPCODE; // bytes received while holding are lost
      endcase
    end
  end

  // command fields, lsb lane first
  always_ff @(posedge HCLK)
  begin
    if (rx_valid)
    begin
      case (state)
        S_OPCODE: cmd.write              <= (rx_byte == uart_ahb_pkg::OP_WRITE);
        S_ADDR:   cmd.addr[8*idx +: 8]   <= rx_byte;
        S_WDATA:  cmd.wdata[8*idx +: 8]  <= rx_byte;
        default:  ;
      endcase
    end
  end

  assign cmd_valid = (state == S_HOLD);

endmodule

/* design/uart_tx.sv */
module uart_tx (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                baud_tick,
  input  logic                tx_start,
  input  uart_ahb_pkg::byte_t tx_byte,
  output logic                tx,
  output logic                tx_done
);

  localparam logic [3:0] LAST_TICK = 4'(uart_ahb_pkg::OVERSAMPLE - 1);
  localparam logic [2:0] LAST_BIT  = 3'(uart_ahb_pkg::DATA_BITS - 1);

  uart_ahb_pkg::uart_state_t state;
  logic [3:0]                tick_cnt;
  logic [2:0]                bit_cnt;
  logic                      tx_reg;
  uart_ahb_pkg::byte_t       shift;
  logic                      bit_end;

  assign bit_end = baud_tick && (tick_cnt == LAST_TICK);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state    <= uart_ahb_pkg::IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      tx_reg   <= 1'b1;
    end
    else
    begin
      if (state != uart_ahb_pkg::IDLE && baud_tick)
        tick_cnt <= tick_cnt + 1'b1;
      case (state)
        uart_ahb_pkg::IDLE:
          if (tx_start)
          begin
            state    <= uart_ahb_pkg::START;
            tick_cnt <= '0;
            tx_reg   <= 1'b0; // start bit
          end
        uart_ahb_pkg::START:
          if (bit_end)
          begin
            state   <= uart_ahb_pkg::DATA;
            bit_cnt <= '0;
            tx_reg  <= shift[0];
          end
        uart_ahb_pkg::DATA:
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT)
            begin
              state  <= uart_ahb_pkg::STOP;
              tx_reg <= 1'b1;
            end
            else
            begin
              tx_reg <= shift[1]; // next bit before the shift lands
            end
          end
        default:
          if (bit_end)
            state <= uart_ahb_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (state == uart_ahb_pkg::IDLE && tx_start)
      shift <= tx_byte;
    else if (state == uart_ahb_pkg::DATA && bit_end)
      shift <= shift >> 1;
  end

  assign tx      = tx_reg;
  assign tx_done = (state == uart_ahb_pkg::STOP) && bit_end;

endmodule

/* design/uart_rx.sv */
module uart_rx (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                baud_tick,
  input  logic                rx,
  output uart_ahb_pkg::byte_t rx_byte,
  output logic                rx_valid
);

  localparam logic [3:0] LAST_TICK = 4'(uart_ahb_pkg::OVERSAMPLE - 1);
  localparam logic [3:0] MID_START = 4'(uart_ahb_pkg::HALF_BIT);
  localparam logic [2:0] LAST_BIT  = 3'(uart_ahb_pkg::DATA_BITS - 1);

  uart_ahb_pkg::uart_state_t state;
  logic [1:0]                rx_sync;  // two-flop synchronizer
  logic                      rx_s;
  logic [3:0]                tick_cnt;
  logic [2:0]                bit_cnt;
  uart_ahb_pkg::byte_t       shift;

  assign rx_s = rx_sync[1];

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      rx_sync  <= 2'b11; // line idles high
      state    <= uart_ahb_pkg::IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      case (state)
        uart_ahb_pkg::IDLE:
          if (!rx_s)
          begin
            state    <= uart_ahb_pkg::START;
            tick_cnt <= '0;
          end
        uart_ahb_pkg::START:
          if (baud_tick)
          begin
            if (tick_cnt == MID_START)
            begin
              // a glitch shorter than half a bit goes back to idle
              state    <= rx_s ? uart_ahb_pkg::IDLE : uart_ahb_pkg::DATA;
              tick_cnt <= '0;
              bit_cnt  <= '0;
            end
            else
            begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        uart_ahb_pkg::DATA:
          if (baud_tick)
          begin
            tick_cnt <= tick_cnt + 1'b1; // wraps every bit
            if (tick_cnt == LAST_TICK)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == LAST_BIT)
                state <= uart_ahb_pkg::STOP;
            end
          end
        default:
          if (baud_tick)
          begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == LAST_TICK)
              state <= uart_ahb_pkg::IDLE;
          end
      endcase
    end
  end

  // lsb first, sampled mid-bit
  always_ff @(posedge HCLK)
  begin
    if (state == uart_ahb_pkg::DATA && baud_tick && tick_cnt == LAST_TICK)
      shift <= {rx_s, shift[7:1]};
  end

  assign rx_byte  = shift;
  assign rx_valid = (state == uart_ahb_pkg::STOP) && baud_tick && (tick_cnt == LAST_TICK);

endmodule

/* design/uart_baud_gen.sv */
module uart_baud_gen #(
  parameter uart_ahb_pkg::prescale_t PRESCALE = 16'd51
) (
  input  logic HCLK,
  input  logic HRESETn,
  output logic baud_tick
);

  uart_ahb_pkg::prescale_t count;

  // wraps at PRESCALE, so one tick per PRESCALE+1 clocks
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      count <= '0;
    end
    else if (count == PRESCALE)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  assign baud_tick = (count == PRESCALE); // 16x bit rate

endmodule

/* design/uart_ahb_pkg.sv */
package uart_ahb_pkg;

  // widths that carry a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [15:0] prescale_t;

  // host command bytes
  localparam byte_t OP_READ  = 8'hA5;
  localparam byte_t OP_WRITE = 8'hA3;

  // 8N1 framing
  localparam int OVERSAMPLE     = 16; // ticks per bit
  localparam int HALF_BIT       = 7;  // mid start bit
  localparam int DATA_BITS      = 8;
  localparam int BYTES_PER_WORD = 4;

  // AHB-Lite codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [2:0] HSIZE_WORD    = 3'b010;

  // one decoded bus command
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } ahb_cmd_t;

  // shared by uart_rx and uart_tx
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage
